// File: all.f
design/uSeqPkg.sv
design/cramStore.sv
design/dispatchMux.sv
design/returnStack.sv
design/crAddrSeq.sv
design/diagRegs.sv
design/microSeqTop.sv
verification/microSeqTb.sv

// File: design/crAddrSeq.sv
`timescale 1ns/1ps
`default_nettype none

module crAddrSeq #(
  parameter int adrWidth       = 11,
  parameter int stackDepthLog2 = 4
) (
  input  wire                                   CLK,
  input  wire                                   rstN,
  input  wire  [adrWidth+uSeqPkg::uwExtraW-1:0] uword,
  input  wire  [adrWidth-1:0]                   dramJ,
  input  wire  [3:0]                            sr,
  input  wire  [7:0]                            condFlags,
  input  wire                                   runEn,
  input  wire                                   stepPulse,
  input  wire                                   forceEn,
  input  wire  [adrWidth-1:0]                   forceAdr,
  output logic [adrWidth-1:0]                   cradr,
  output logic [adrWidth-1:0]                   retTop,
  output logic [stackDepthLog2-1:0]             stackPtr
);

  logic                adv;
  logic                isCall;
  logic                isReturn;
  logic [adrWidth-1:0] jField;
  logic [adrWidth-1:0] dispBits;

  assign jField = uword[adrWidth-1:0];
  assign isCall = uword[adrWidth+uSeqPkg::callOfs];
  assign adv    = runEn | stepPulse;

  dispatchMux #(
    .adrWidth (adrWidth)
  ) uDispatch (
    .uword     (uword),
    .dramJ     (dramJ),
    .sr        (sr),
    .condFlags (condFlags),
    .retTop    (retTop),
    .dispBits  (dispBits),
    .isReturn  (isReturn)
  );

  // Stack only moves when the sequencer advances and no jump is forced
  returnStack #(
    .adrWidth       (adrWidth),
    .stackDepthLog2 (stackDepthLog2)
  ) uStack (
    .CLK      (CLK),
    .rstN     (rstN),
    .push     (adv & isCall & ~forceEn),
    .pop      (adv & isReturn & ~forceEn),
    .pushAdr  (cradr),
    .retTop   (retTop),
    .stackPtr (stackPtr)
  );

  //////////////////////////////
  // Address register
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      cradr <= '0;
    end else if (forceEn) begin
      cradr <= forceAdr;
    end else if (adv) begin
      cradr <= jField | dispBits;
    end
  end

endmodule

`default_nettype wire

// File: design/cramStore.sv
`timescale 1ns/1ps
`default_nettype none

module cramStore #(
  parameter int adrWidth = 11
) (
  input  wire                                      CLK,
  // Fetch port, driven by the sequencer
  input  wire  [adrWidth-1:0]                      cradr,
  output logic [adrWidth+uSeqPkg::uwExtraW-1:0]    uword,
  // Diagnostic readback port
  input  wire  [adrWidth-1:0]                      loadAdr,
  output logic [adrWidth+uSeqPkg::uwExtraW-1:0]    loadRdata,
  // Diagnostic load port
  input  wire                                      cramWe,
  input  wire  [adrWidth-1:0]                      cramWadr,
  input  wire  [adrWidth+uSeqPkg::uwExtraW-1:0]    cramWdata
);

  localparam int uwW   = adrWidth + uSeqPkg::uwExtraW;
  localparam int depth = 2 ** adrWidth;

  // Control store, contents undefined until loaded
  logic [uwW-1:0] mem [depth];

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Both reads are combinational so the fetch fits the same cycle
  assign uword     = mem[cradr];
  assign loadRdata = mem[loadAdr];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (cramWe) begin
      mem[cramWadr] <= cramWdata;
    end
  end

endmodule

`default_nettype wire

// File: design/diagRegs.sv
`timescale 1ns/1ps
`default_nettype none

module diagRegs #(
  parameter int adrWidth       = 11,
  parameter int stackDepthLog2 = 4
) (
  input  wire                                   CLK,
  input  wire                                   rstN,
  // Four-phase host port
  input  wire                                   diagReq,
  input  wire                                   diagWe,
  input  wire  uSeqPkg::diagReg                 diagSel,
  input  wire  [31:0]                           diagWdata,
  output logic                                  diagAck,
  output logic [31:0]                           diagRdata,
  // Sequencer control
  output logic                                  runEn,
  output logic                                  stepPulse,
  output logic                                  forceEn,
  output logic [adrWidth-1:0]                   forceAdr,
  // Control store load and readback
  output logic                                  cramWe,
  output logic [adrWidth-1:0]                   cramWadr,
  output logic [adrWidth+uSeqPkg::uwExtraW-1:0] cramWdata,
  output logic [adrWidth-1:0]                   loadAdr,
  input  wire  [adrWidth+uSeqPkg::uwExtraW-1:0] loadRdata,
  // Sequencer status
  input  wire  [adrWidth-1:0]                   cradr,
  input  wire  [adrWidth-1:0]                   retTop,
  input  wire  [stackDepthLog2-1:0]             stackPtr
);

  localparam int uwW = adrWidth + uSeqPkg::uwExtraW;

  typedef enum logic {
    stIdle,
    stAck
  } hsState;

  hsState      state;
  logic        access;
  logic [31:0] rdMux;

  // New request seen while idle
  assign access  = (state == stIdle) && diagReq;
  assign diagAck = (state == stAck);

  //////////////////////////////
  // Handshake and control
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state     <= stIdle;
      runEn     <= 1'b0;
      stepPulse <= 1'b0;
      forceEn   <= 1'b0;
      cramWe    <= 1'b0;
      loadAdr   <= '0;
    end else begin
      // Pulses last a single cycle
      stepPulse <= 1'b0;
      forceEn   <= 1'b0;
      cramWe    <= 1'b0;
      case (state)
        stIdle: begin
          if (diagReq) begin
            state <= stAck;
            if (diagWe) begin
              case (diagSel)
                uSeqPkg::regCtrl: begin
                  runEn     <= diagWdata[0];
                  stepPulse <= diagWdata[1];
                end
                uSeqPkg::regLoadAdr:  loadAdr <= diagWdata[adrWidth-1:0];
                uSeqPkg::regLoadData: begin
                  cramWe  <= 1'b1;
                  loadAdr <= loadAdr + 1'b1;
                end
                uSeqPkg::regJump:     forceEn <= 1'b1;
                default: ;
              endcase
            end
          end
        end
        default: begin
          // Wait for the host to drop its request
          if (!diagReq) begin
            state <= stIdle;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Payload registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (access && diagWe && diagSel == uSeqPkg::regLoadData) begin
      cramWadr  <= loadAdr;
      cramWdata <= diagWdata[uwW-1:0];
    end
    if (access && diagWe && diagSel == uSeqPkg::regJump) begin
      forceAdr <= diagWdata[adrWidth-1:0];
    end
    if (access) begin
      diagRdata <= rdMux;
    end
  end

  // Readback select; regStack packs stackPtr at bit 16 and retTop at bit 0
  always_comb begin
    rdMux = '0;
    case (diagSel)
      uSeqPkg::regCtrl:     rdMux[0] = runEn;
      uSeqPkg::regLoadAdr:  rdMux[adrWidth-1:0] = loadAdr;
      uSeqPkg::regLoadData: rdMux[uwW-1:0] = loadRdata;
      uSeqPkg::regJump:     rdMux[adrWidth-1:0] = forceAdr;
      uSeqPkg::regCradr:    rdMux[adrWidth-1:0] = cradr;
      uSeqPkg::regStack: begin
        rdMux[adrWidth-1:0]            = retTop;
        rdMux[16 +: stackDepthLog2]    = stackPtr;
      end
      default: rdMux = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/dispatchMux.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchMux #(
  parameter int adrWidth = 11
) (
  input  wire  [adrWidth+uSeqPkg::uwExtraW-1:0] uword,
  input  wire  [adrWidth-1:0]                   dramJ,
  input  wire  [3:0]                            sr,
  input  wire  [7:0]                            condFlags,
  input  wire  [adrWidth-1:0]                   retTop,
  output logic [adrWidth-1:0]                   dispBits,
  output logic                                  isReturn
);

  uSeqPkg::dispMode            mode;
  logic [uSeqPkg::condW-1:0]   cond;
  logic [uSeqPkg::dispW-1:0]   dispField;

  // Field extraction from the current microword
  assign dispField = uword[adrWidth+uSeqPkg::dispOfs +: uSeqPkg::dispW];
  assign cond      = uword[adrWidth+uSeqPkg::condOfs +: uSeqPkg::condW];
  assign mode      = uSeqPkg::dispMode'(dispField);

  //////////////////////////////
  // Dispatch select
  //////////////////////////////

  always_comb begin
    dispBits = '0;
    isReturn = 1'b0;
    case (mode)
      uSeqPkg::dispReturn: begin
        // Return address comes off the stack, which pops
        dispBits = retTop;
        isReturn = 1'b1;
      end
      uSeqPkg::dispDram: begin
        dispBits = dramJ;
      end
      uSeqPkg::dispSr: begin
        // Switch register lands in the low nibble
        dispBits[3:0] = sr;
      end
      uSeqPkg::dispSkip: begin
        // Selected condition flag makes a two-way branch
        dispBits[0] = condFlags[cond];
      end
      default: begin
        // Plain jump and the reserved codes
        dispBits = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/microSeqTop.sv
`timescale 1ns/1ps
`default_nettype none

module microSeqTop #(
  parameter int adrWidth       = 11,
  parameter int stackDepthLog2 = 4
) (
  input  wire                                   CLK,
  input  wire                                   rstN,
  input  wire  [adrWidth-1:0]                   dramJ,
  input  wire  [3:0]                            sr,
  input  wire  [7:0]                            condFlags,
  // Diagnostic port
  input  wire                                   diagReq,
  input  wire                                   diagWe,
  input  wire  uSeqPkg::diagReg                 diagSel,
  input  wire  [31:0]                           diagWdata,
  output logic                                  diagAck,
  output logic [31:0]                           diagRdata,
  // Sequencer outputs
  output logic [adrWidth-1:0]                   cradr,
  output logic [adrWidth+uSeqPkg::uwExtraW-1:0] uword
);

  localparam int uwW = adrWidth + uSeqPkg::uwExtraW;

  logic                      runEn;
  logic                      stepPulse;
  logic                      forceEn;
  logic [adrWidth-1:0]       forceAdr;
  logic                      cramWe;
  logic [adrWidth-1:0]       cramWadr;
  logic [uwW-1:0]            cramWdata;
  logic [adrWidth-1:0]       loadAdr;
  logic [uwW-1:0]            loadRdata;
  logic [adrWidth-1:0]       retTop;
  logic [stackDepthLog2-1:0] stackPtr;

  //////////////////////////////
  // Control store
  //////////////////////////////

  cramStore #(
    .adrWidth (adrWidth)
  ) uCram (
    .CLK       (CLK),
    .cradr     (cradr),
    .uword     (uword),
    .loadAdr   (loadAdr),
    .loadRdata (loadRdata),
    .cramWe    (cramWe),
    .cramWadr  (cramWadr),
    .cramWdata (cramWdata)
  );

  //////////////////////////////
  // Address sequencer
  //////////////////////////////

  crAddrSeq #(
    .adrWidth       (adrWidth),
    .stackDepthLog2 (stackDepthLog2)
  ) uSeq (
    .CLK       (CLK),
    .rstN      (rstN),
    .uword     (uword),
    .dramJ     (dramJ),
    .sr        (sr),
    .condFlags (condFlags),
    .runEn     (runEn),
    .stepPulse (stepPulse),
    .forceEn   (forceEn),
    .forceAdr  (forceAdr),
    .cradr     (cradr),
    .retTop    (retTop),
    .stackPtr  (stackPtr)
  );

  //////////////////////////////
  // Diagnostic block
  //////////////////////////////

  diagRegs #(
    .adrWidth       (adrWidth),
    .stackDepthLog2 (stackDepthLog2)
  ) uDiag (
    .CLK       (CLK),
    .rstN      (rstN),
    .diagReq   (diagReq),
    .diagWe    (diagWe),
    .diagSel   (diagSel),
    .diagWdata (diagWdata),
    .diagAck   (diagAck),
    .diagRdata (diagRdata),
    .runEn     (runEn),
    .stepPulse (stepPulse),
    .forceEn   (forceEn),
    .forceAdr  (forceAdr),
    .cramWe    (cramWe),
    .cramWadr  (cramWadr),
    .cramWdata (cramWdata),
    .loadAdr   (loadAdr),
    .loadRdata (loadRdata),
    .cradr     (cradr),
    .retTop    (retTop),
    .stackPtr  (stackPtr)
  );

endmodule

`default_nettype wire

// File: design/returnStack.sv
`timescale 1ns/1ps
`default_nettype none

module returnStack #(
  parameter int adrWidth       = 11,
  parameter int stackDepthLog2 = 4
) (
  input  wire                       CLK,
  input  wire                       rstN,
  input  wire                       push,
  input  wire                       pop,
  input  wire  [adrWidth-1:0]       pushAdr,
  output logic [adrWidth-1:0]       retTop,
  output logic [stackDepthLog2-1:0] stackPtr
);

  localparam int depth = 2 ** stackDepthLog2;

  logic [adrWidth-1:0] stack [depth];

  // Top of stack is the entry under the pointer
  assign retTop = stack[stackPtr];

  //////////////////////////////
  // Pointer
  //////////////////////////////

  // Wraps silently in both directions
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      stackPtr <= '0;
    end else if (push && !pop) begin
      stackPtr <= stackPtr + 1'b1;
    end else if (pop && !push) begin
      stackPtr <= stackPtr - 1'b1;
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (push && pop) begin
      // Call with return replaces the top entry in place
      stack[stackPtr] <= pushAdr;
    end else if (push) begin
      stack[stackPtr + 1'b1] <= pushAdr;
    end
  end

endmodule

`default_nettype wire

// File: design/uSeqPkg.sv
`default_nettype none

package uSeqPkg;

  // Microword field widths
  parameter int dispW = 3;
  parameter int condW = 3;

  //////////////////////////////
  // Microword layout
  //////////////////////////////
  // J is the low adrWidth bits; these offsets count from the bit above J
  parameter int condOfs = 0;
  parameter int dispOfs = condOfs + condW;
  parameter int callOfs = dispOfs + dispW;

  // Bits on top of J, so the microword is adrWidth + uwExtraW wide
  parameter int uwExtraW = callOfs + 1;

  // Dispatch modes, unlisted codes act as dispJump
  typedef enum logic [dispW-1:0] {
    dispJump   = 3'd0,
    dispReturn = 3'd1,
    dispDram   = 3'd2,
    dispSr     = 3'd3,
    dispSkip   = 3'd4
  } dispMode;

  // Diagnostic register select
  typedef enum logic [2:0] {
    regCtrl     = 3'd0,
    regLoadAdr  = 3'd1,
    regLoadData = 3'd2,
    regJump     = 3'd3,
    regCradr    = 3'd4,
    regStack    = 3'd5
  } diagReg;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the microcode sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
  --top-module microSeqTb \
  -f all.f \
  -o simv \
  && ./obj_dir/simv > "$LOG" 2>&1

cat "$LOG" 2> /dev/null

grep -q "ALL TESTS PASSED" "$LOG" 2> /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/microSeqTb.sv
`timescale 1ns/1ps
`default_nettype none

module microSeqTb;

  localparam int adrW          = 11;
  localparam int stackLog2     = 4;
  localparam int uwW           = adrW + uSeqPkg::uwExtraW;
  localparam int depth         = 1 << adrW;
  localparam int timeoutCycles = depth * 16 + 5000;

  logic                 CLK;
  logic                 rstN;
  logic [adrW-1:0]      dramJ;
  logic [3:0]           sr;
  logic [7:0]           condFlags;
  logic                 diagReq;
  logic                 diagWe;
  uSeqPkg::diagReg      diagSel;
  logic [31:0]          diagWdata;
  logic                 diagAck;
  logic [31:0]          diagRdata;
  logic [adrW-1:0]      cradr;
  logic [uwW-1:0]       uword;

  // Reference model state
  logic [uwW-1:0]       mStore [depth];
  logic [adrW-1:0]      mStack [1 << stackLog2];
  logic [stackLog2-1:0] mPtr;
  logic [adrW-1:0]      mCradr;
  logic [31:0]          lfsrState;

  microSeqTop #(
    .adrWidth       (adrW),
    .stackDepthLog2 (stackLog2)
  ) dut (
    .CLK       (CLK),
    .rstN      (rstN),
    .dramJ     (dramJ),
    .sr        (sr),
    .condFlags (condFlags),
    .diagReq   (diagReq),
    .diagWe    (diagWe),
    .diagSel   (diagSel),
    .diagWdata (diagWdata),
    .diagAck   (diagAck),
    .diagRdata (diagRdata),
    .cradr     (cradr),
    .uword     (uword)
  );

  always #4 CLK = ~CLK;

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic failNow(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping on first mismatch");
  endtask

  task automatic checkAdr(input logic [adrW-1:0] got, input logic [adrW-1:0] exp,
                          input string what);
    if (got !== exp) begin
      failNow($sformatf("%s address got %h expected %h", what, got, exp));
    end
  endtask

  task automatic checkWord(input logic [uwW-1:0] got, input logic [uwW-1:0] exp,
                           input string what);
    if (got !== exp) begin
      failNow($sformatf("%s microword got %h expected %h", what, got, exp));
    end
  endtask

  task automatic checkDiag(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    if (got !== exp) begin
      failNow($sformatf("%s readback got %h expected %h", what, got, exp));
    end
  endtask

  //////////////////////////////
  // Diagnostic bus
  //////////////////////////////

  // All bus tasks start and end 1 ns after a rising edge
  task automatic waitAck(input logic level);
    do begin
      @(posedge CLK);
      #1;
    end while (diagAck !== level);
  endtask

  task automatic diagWrite(input uSeqPkg::diagReg sel, input logic [31:0] data);
    diagSel   = sel;
    diagWe    = 1'b1;
    diagWdata = data;
    diagReq   = 1'b1;
    waitAck(1'b1);
    diagReq = 1'b0;
    waitAck(1'b0);
  endtask

  task automatic diagRead(input uSeqPkg::diagReg sel, output logic [31:0] data);
    diagSel = sel;
    diagWe  = 1'b0;
    diagReq = 1'b1;
    waitAck(1'b1);
    data    = diagRdata;
    diagReq = 1'b0;
    waitAck(1'b0);
  endtask

  task automatic loadWord(input logic [adrW-1:0] adr, input logic [uwW-1:0] w);
    mStore[adr] = w;
    diagWrite(uSeqPkg::regLoadAdr, 32'(adr));
    diagWrite(uSeqPkg::regLoadData, 32'(w));
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // One advance of the sequencer with the inputs now driven
  task automatic modelStep();
    logic [uwW-1:0]  w;
    logic [adrW-1:0] bits;
    logic            ret;
    w    = mStore[mCradr];
    bits = '0;
    ret  = 1'b0;
    case (w[adrW+3 +: 3])
      3'd1: begin
        bits = mStack[mPtr];
        ret  = 1'b1;
      end
      3'd2: bits = dramJ;
      3'd3: bits = {{(adrW-4){1'b0}}, sr};
      3'd4: bits = {{(adrW-1){1'b0}}, condFlags[w[adrW +: 3]]};
      default: bits = '0;
    endcase
    if (w[uwW-1] && ret) begin
      mStack[mPtr] = mCradr;
    end else if (w[uwW-1]) begin
      mPtr = mPtr + 1'b1;
      mStack[mPtr] = mCradr;
    end else if (ret) begin
      mPtr = mPtr - 1'b1;
    end
    mCradr = w[adrW-1:0] | bits;
  endtask

  // Running cycles, checked at the top port each edge
  task automatic runCycles(input int n, input logic randomize);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      if (randomize) begin
        r         = randBits(adrW + 12);
        dramJ     = r[adrW-1:0];
        sr        = r[adrW +: 4];
        condFlags = r[adrW+4 +: 8];
      end
      modelStep();
      @(posedge CLK);
      #1;
      checkAdr(cradr, mCradr, "free run");
      checkWord(uword, mStore[mCradr], "fetch");
    end
  endtask

  task automatic startRun();
    diagWrite(uSeqPkg::regCtrl, 32'd1);
    modelStep();
    checkAdr(cradr, mCradr, "run start");
  endtask

  // The access edge of the stop write still advances once
  task automatic stopRun();
    diagWrite(uSeqPkg::regCtrl, 32'd0);
    modelStep();
    checkAdr(cradr, mCradr, "run stop");
  endtask

  task automatic checkStack();
    logic [31:0] rd;
    diagRead(uSeqPkg::regStack, rd);
    checkDiag(rd, (32'(mPtr) << 16) | 32'(mStack[mPtr]), "stack");
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    repeat (timeoutCycles) @(posedge CLK);
    $display("Timeout: the tests did not finish in %0d cycles", timeoutCycles);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] tgt;
    CLK       = 1'b0;
    rstN      = 1'b0;
    dramJ     = '0;
    sr        = '0;
    condFlags = '0;
    diagReq   = 1'b0;
    diagWe    = 1'b0;
    diagSel   = uSeqPkg::regCtrl;
    diagWdata = '0;
    lfsrState = 32'h1ab9;
    mPtr      = '0;
    mCradr    = '0;
    repeat (2) @(posedge CLK);
    #1;
    rstN = 1'b1;

    // Reset state
    checkAdr(cradr, '0, "reset");
    if (diagAck !== 1'b0) begin
      failNow("diagAck is not low after reset");
    end
    diagRead(uSeqPkg::regStack, rd);
    checkDiag(rd & 32'h000f0000, 32'h0, "reset stack pointer");

    // Load the whole store with auto-increment, then read it back
    diagWrite(uSeqPkg::regLoadAdr, 32'd0);
    for (int a = 0; a < depth; a++) begin
      mStore[a] = randBits(uwW);
      diagWrite(uSeqPkg::regLoadData, 32'(mStore[a]));
    end
    for (int a = 0; a < depth; a++) begin
      diagWrite(uSeqPkg::regLoadAdr, 32'(a));
      diagRead(uSeqPkg::regLoadData, rd);
      checkWord(rd[uwW-1:0], mStore[a], "load readback");
    end

    // Call chain deeper than the stack, ending in call with return
    for (int a = 0; a < 20; a++) begin
      loadWord(adrW'(12'h400 + a), {1'b1, 3'd0, 3'd0, adrW'(12'h401 + a)});
    end
    loadWord(adrW'(12'h414), {1'b1, 3'd1, 3'd0, {adrW{1'b0}}});
    diagWrite(uSeqPkg::regJump, 32'h400);
    mCradr = adrW'(12'h400);
    checkAdr(cradr, mCradr, "forced jump while halted");
    startRun();
    runCycles(60, 1'b0);
    stopRun();
    checkStack();

    // Single step with the sequencer halted
    for (int i = 0; i < 12; i++) begin
      repeat (3) @(posedge CLK);
      #1;
      checkAdr(cradr, mCradr, "halted hold");
      diagWrite(uSeqPkg::regCtrl, 32'd2);
      modelStep();
      diagRead(uSeqPkg::regCradr, rd);
      checkDiag(rd, 32'(mCradr), "single step");
    end

    // Overwrite the call chain so the free run walks random words
    for (int a = 12'h400; a <= 12'h414; a++) begin
      loadWord(adrW'(a), randBits(uwW));
    end
    diagWrite(uSeqPkg::regJump, 32'd0);
    mCradr = '0;
    checkAdr(cradr, mCradr, "free run start");

    // Free run with random dispatch inputs
    startRun();
    runCycles(600, 1'b1);
    stopRun();
    checkStack();

    // Forced jump while running
    startRun();
    runCycles(20, 1'b1);
    tgt = randBits(adrW);
    diagWrite(uSeqPkg::regJump, tgt);
    modelStep();
    mCradr = tgt[adrW-1:0];
    checkAdr(cradr, mCradr, "forced jump while running");
    stopRun();
    checkStack();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
